/* verification/mem_stage_vectors.txt */
# name ld_op st_op addr rs2_data pc_next rd rd_wr wrb_sel then exc exp_rd_wr exp_data, all hex
# ld_op 0 none 1 lb 2 lbu 3 lh 4 lhu 5 lw; st_op 0 none 1 sb 2 sh 3 sw; wrb_sel 0 alu 1 mem 2 pc
sw_100      0 3 00000100 deadbeef 00001004 00 0 1 0 0 00000000
lw_100      5 0 00000100 00000000 00001008 05 1 1 0 1 deadbeef
sb_200      0 1 00000200 00000081 0000100c 00 0 1 0 0 00000000
sb_201      0 1 00000201 1234567f 00001010 00 0 1 0 0 00000000
sb_202      0 1 00000202 000000c3 00001014 00 0 1 0 0 00000000
sb_203      0 1 00000203 00000024 00001018 00 0 1 0 0 00000000
lb_200      1 0 00000200 00000000 0000101c 06 1 1 0 1 ffffff81
lbu_200     2 0 00000200 00000000 00001020 07 1 1 0 1 00000081
lb_201      1 0 00000201 00000000 00001024 08 1 1 0 1 0000007f
lb_202      1 0 00000202 00000000 00001028 09 1 1 0 1 ffffffc3
lbu_202     2 0 00000202 00000000 0000102c 0a 1 1 0 1 000000c3
lbu_203     2 0 00000203 00000000 00001030 0b 1 1 0 1 00000024
lh_200      3 0 00000200 00000000 00001034 0c 1 1 0 1 00007f81
lhu_202     4 0 00000202 00000000 00001038 0d 1 1 0 1 000024c3
lw_200      5 0 00000200 00000000 0000103c 0e 1 1 0 1 24c37f81
sh_300      0 2 00000300 55558001 00001040 00 0 1 0 0 00000000
sh_302      0 2 00000302 00009abc 00001044 00 0 1 0 0 00000000
lh_300      3 0 00000300 00000000 00001048 0f 1 1 0 1 ffff8001
lhu_300     4 0 00000300 00000000 0000104c 10 1 1 0 1 00008001
lh_302      3 0 00000302 00000000 00001050 11 1 1 0 1 ffff9abc
alu_r3      0 0 0000abcd 00000000 00002000 03 1 0 0 1 0000abcd
pc_r1       0 0 11111111 00000000 00002004 01 1 2 0 1 00002004
nowr_r7     0 0 00000055 00000000 00002008 07 0 0 0 0 00000000
sh_mis      0 2 00000301 0000ffff 0000200c 00 0 1 1 0 00000301
sw_mis      0 3 00000102 00000000 00002010 00 0 1 1 0 00000102
lw_mis      5 0 00000203 00000000 00002014 04 1 1 1 0 00000203
lh_mis      3 0 00000201 00000000 00002018 04 1 1 1 0 00000201
lw_300_chk  5 0 00000300 00000000 0000201c 12 1 1 0 1 9abc8001
lw_100_chk  5 0 00000100 00000000 00002020 13 1 1 0 1 deadbeef
lw_wrap     5 0 00000500 00000000 00002024 14 1 1 0 1 deadbeef
sw_104      0 3 00000104 cafef00d 00003000 00 0 1 0 0 00000000
alu_r9      0 0 00000999 00000000 00003004 09 1 0 0 1 00000999
lw_104      5 0 00000104 00000000 00003008 15 1 1 0 1 cafef00d
pc_r11      0 0 00000000 00000000 0000300c 0b 1 2 0 1 0000300c
lbu_107     2 0 00000107 00000000 00003010 16 1 1 0 1 000000ca
lh_106      3 0 00000106 00000000 00003014 17 1 1 0 1 ffffcafe
sb_105      0 1 00000105 0000005a 00003018 00 0 1 0 0 00000000
lw_104_new  5 0 00000104 00000000 0000301c 18 1 1 0 1 cafe5a0d

/* build.f */
common/lsu_pkg.sv
common/dbus_pkg.sv
lsu/lsu.sv
lsu/lsu_dbus_ctrl.sv
rtl/data_mem.sv
rtl/lsu_wrb.sv
rtl/mem_stage_top.sv
verification/mem_stage_checker.sv
verification/tb_mem_stage.sv

/* Bender.yml */
package:
  name: mem_stage

sources:
  # Shared packages
  - files:
      - common/lsu_pkg.sv
      - common/dbus_pkg.sv
  # Design
  - files:
      - lsu/lsu.sv
      - lsu/lsu_dbus_ctrl.sv
      - rtl/data_mem.sv
      - rtl/lsu_wrb.sv
      - rtl/mem_stage_top.sv
  # Testbench
  - target: test
    files:
      - verification/mem_stage_checker.sv
      - verification/tb_mem_stage.sv

/* verification/tb_mem_stage.sv */
`default_nettype none

module tb_mem_stage import lsu_pkg::*; ();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int MEM_WORDS     = 256;
   localparam int ACK_TIMEOUT   = 100;
   localparam int DRAIN_TIMEOUT = 200;

   logic        clk;
   logic        rst;
   logic        exe_req;
   logic        exe_ack;
   ld_ops_e     exe_ld_ops;
   st_ops_e     exe_st_ops;
   xlen_data_t  exe_alu_result;
   xlen_data_t  exe_rs2_data;
   xlen_data_t  exe_pc_next;
   reg_addr_t   exe_rd_addr;
   logic        exe_rd_wr_req;
   rd_wrb_sel_e exe_rd_wrb_sel;

   logic        wrb_valid;
   logic        wrb_rd_wr;
   reg_addr_t   wrb_rd_addr;
   xlen_data_t  wrb_data;
   logic        exc;
   xlen_data_t  exc_addr;

   int          checked;
   int          mismatch_count;
   int          error_count;
   int          pending;
   int          issued;
   int          drive_errors;
   logic        abort;
   logic [31:0] rng_state;

   // Fields of the current vector line
   logic [127:0] v_name;
   logic [31:0]  v_ld;
   logic [31:0]  v_st;
   logic [31:0]  v_addr;
   logic [31:0]  v_rs2;
   logic [31:0]  v_pc;
   logic [31:0]  v_rd;
   logic [31:0]  v_wr;
   logic [31:0]  v_sel;
   logic [31:0]  v_exc;
   logic [31:0]  v_exp_wr;
   logic [31:0]  v_exp_data;

   mem_stage_top #(
      .MEM_WORDS (MEM_WORDS)
   ) u_mem_stage_top (
      .clk              (clk),
      .rst_i            (rst),
      .exe_req_i        (exe_req),
      .exe_ack_o        (exe_ack),
      .exe_ld_ops_i     (exe_ld_ops),
      .exe_st_ops_i     (exe_st_ops),
      .exe_alu_result_i (exe_alu_result),
      .exe_rs2_data_i   (exe_rs2_data),
      .exe_pc_next_i    (exe_pc_next),
      .exe_rd_addr_i    (exe_rd_addr),
      .exe_rd_wr_req_i  (exe_rd_wr_req),
      .exe_rd_wrb_sel_i (exe_rd_wrb_sel),
      .wrb_valid_o      (wrb_valid),
      .wrb_rd_wr_o      (wrb_rd_wr),
      .wrb_rd_addr_o    (wrb_rd_addr),
      .wrb_data_o       (wrb_data),
      .exc_o            (exc),
      .exc_addr_o       (exc_addr)
   );

   mem_stage_checker u_mem_stage_checker (
      .clk              (clk),
      .rst_i            (rst),
      .wrb_valid_i      (wrb_valid),
      .wrb_rd_wr_i      (wrb_rd_wr),
      .wrb_rd_addr_i    (wrb_rd_addr),
      .wrb_data_i       (wrb_data),
      .exc_i            (exc),
      .exc_addr_i       (exc_addr),
      .checked_o        (checked),
      .mismatch_count_o (mismatch_count),
      .error_count_o    (error_count),
      .pending_o        (pending)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] state);
      logic [31:0] x;
      x = state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Four-phase exchange on the execute port for the current vector
   task automatic issue_operation();
      int wait_cnt;
      @(posedge clk);
      u_mem_stage_checker.push_expected(v_name, v_exc[0], v_exp_wr[0], v_rd[4:0], v_exp_data);
      issued++;
      exe_req        <= 1'b1;
      exe_ld_ops     <= ld_ops_e'(v_ld[2:0]);
      exe_st_ops     <= st_ops_e'(v_st[1:0]);
      exe_alu_result <= v_addr;
      exe_rs2_data   <= v_rs2;
      exe_pc_next    <= v_pc;
      exe_rd_addr    <= v_rd[4:0];
      exe_rd_wr_req  <= v_wr[0];
      exe_rd_wrb_sel <= rd_wrb_sel_e'(v_sel[1:0]);
      wait_cnt = 0;
      @(negedge clk);
      while (!exe_ack && wait_cnt < ACK_TIMEOUT) begin
         @(negedge clk);
         wait_cnt++;
      end
      if (!exe_ack) begin
         $display("ERROR: %0s was never acknowledged on the execute port", v_name);
         drive_errors++;
         abort = 1'b1;
      end
      @(posedge clk);
      exe_req <= 1'b0;
      if (!abort) begin
         wait_cnt = 0;
         @(negedge clk);
         while (exe_ack && wait_cnt < ACK_TIMEOUT) begin
            @(negedge clk);
            wait_cnt++;
         end
         if (exe_ack) begin
            $display("ERROR: execute port ack stayed high after %0s was released", v_name);
            drive_errors++;
            abort = 1'b1;
         end
      end
   endtask

   initial begin : stimulus
      int               fd;
      int               got;
      int               fields;
      int               wait_cnt;
      logic [8*200-1:0] line_buf;

      rst            = 1'b1;
      exe_req        = 1'b0;
      exe_ld_ops     = LD_OPS_NONE;
      exe_st_ops     = ST_OPS_NONE;
      exe_alu_result = '0;
      exe_rs2_data   = '0;
      exe_pc_next    = '0;
      exe_rd_addr    = '0;
      exe_rd_wr_req  = 1'b0;
      exe_rd_wrb_sel = RD_WRB_ALU;
      issued         = 0;
      drive_errors   = 0;
      abort          = 1'b0;
      rng_state      = 32'h11a0;
      repeat (4) @(posedge clk);
      rst <= 1'b0;

      fd = $fopen("verification/mem_stage_vectors.txt", "r");
      if (fd == 0) begin
         $display("ERROR: cannot open verification/mem_stage_vectors.txt");
         drive_errors++;
      end else begin
         while (!$feof(fd) && !abort) begin
            line_buf = '0;
            got = $fgets(line_buf, fd);
            fields = $sscanf(line_buf, "%s %h %h %h %h %h %h %h %h %h %h %h", v_name, v_ld,
                             v_st, v_addr, v_rs2, v_pc, v_rd, v_wr, v_sel, v_exc, v_exp_wr,
                             v_exp_data);
            // Comment and blank lines never fill every column
            if (got > 0 && fields == 12) begin
               issue_operation();
               rng_state = xorshift32(rng_state);
               repeat (rng_state[1:0]) @(posedge clk);
            end
         end
         $fclose(fd);
      end

      // Let the last results drain out of the pipeline
      @(posedge clk);
      wait_cnt = 0;
      while (pending != 0 && wait_cnt < DRAIN_TIMEOUT) begin
         @(posedge clk);
         wait_cnt++;
      end
      if (pending != 0) begin
         $display("ERROR: %0d expected results never arrived", pending);
         drive_errors++;
      end
      if (issued == 0) begin
         $display("ERROR: no operations were read from the vector file");
         drive_errors++;
      end
      repeat (4) @(posedge clk);

      $display("Issued %0d, checked %0d, mismatches %0d, other errors %0d", issued, checked,
               mismatch_count, error_count + drive_errors);
      if (mismatch_count == 0 && error_count + drive_errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule : tb_mem_stage

`default_nettype wire

/* verification/mem_stage_checker.sv */
`default_nettype none

module mem_stage_checker import lsu_pkg::*; (
   input  logic       clk,
   input  logic       rst_i,
   input  logic       wrb_valid_i,
   input  logic       wrb_rd_wr_i,
   input  reg_addr_t  wrb_rd_addr_i,
   input  xlen_data_t wrb_data_i,
   input  logic       exc_i,
   input  xlen_data_t exc_addr_i,
   output int         checked_o,
   output int         mismatch_count_o,
   output int         error_count_o,
   output int         pending_o
);

   timeunit 1ns;
   timeprecision 1ps;

   localparam int RESULT_TIMEOUT = 64;

   // Expected results in issue order
   logic [127:0] exp_name_q[$];
   logic         exp_exc_q[$];
   logic         exp_wr_q[$];
   reg_addr_t    exp_rd_q[$];
   xlen_data_t   exp_data_q[$];
   int           wait_cycles;

   task automatic push_expected(input logic [127:0] name, input logic exc_exp,
                                input logic wr_exp, input reg_addr_t rd_exp,
                                input xlen_data_t data_exp);
      exp_name_q.push_back(name);
      exp_exc_q.push_back(exc_exp);
      exp_wr_q.push_back(wr_exp);
      exp_rd_q.push_back(rd_exp);
      exp_data_q.push_back(data_exp);
   endtask

   task automatic compare_field(input logic [127:0] name, input string field,
                                input logic [31:0] exp_val, input logic [31:0] act_val);
      if (exp_val !== act_val) begin
         $display("MISMATCH %0s %0s: expected %h, actual %h", name, field, exp_val, act_val);
         mismatch_count_o++;
      end
   endtask

   task automatic compare_result();
      logic [127:0] name;
      logic         exc_exp;
      logic         wr_exp;
      reg_addr_t    rd_exp;
      xlen_data_t   data_exp;
      name     = exp_name_q.pop_front();
      exc_exp  = exp_exc_q.pop_front();
      wr_exp   = exp_wr_q.pop_front();
      rd_exp   = exp_rd_q.pop_front();
      data_exp = exp_data_q.pop_front();
      checked_o++;
      compare_field(name, "exception", {31'b0, exc_exp}, {31'b0, exc_i});
      if (exc_exp && exc_i) begin
         // An exception replaces the writeback pulse
         compare_field(name, "wrb_valid", 32'd0, {31'b0, wrb_valid_i});
         compare_field(name, "exc_addr", data_exp, exc_addr_i);
      end else if (!exc_exp && !exc_i) begin
         compare_field(name, "rd_wr", {31'b0, wr_exp}, {31'b0, wrb_rd_wr_i});
         // Address and data only matter when rd is written
         if (wr_exp && wrb_rd_wr_i) begin
            compare_field(name, "rd_addr", {27'b0, rd_exp}, {27'b0, wrb_rd_addr_i});
            compare_field(name, "data", data_exp, wrb_data_i);
         end
      end
   endtask

   // Outputs settle after the rising edge, so look at them on the falling edge
   always @(negedge clk) begin
      if (rst_i) begin
         wait_cycles = 0;
      end else if (wrb_valid_i || exc_i) begin
         wait_cycles = 0;
         if (exp_exc_q.size() == 0) begin
            $display("ERROR: result for rd %0d arrived with no operation outstanding",
                     wrb_rd_addr_i);
            error_count_o++;
         end else begin
            compare_result();
         end
      end else if (exp_exc_q.size() != 0) begin
         wait_cycles++;
         if (wait_cycles > RESULT_TIMEOUT) begin
            $display("ERROR: timeout, no result for %0s within %0d cycles", exp_name_q[0],
                     RESULT_TIMEOUT);
            error_count_o++;
            void'(exp_name_q.pop_front());
            void'(exp_exc_q.pop_front());
            void'(exp_wr_q.pop_front());
            void'(exp_rd_q.pop_front());
            void'(exp_data_q.pop_front());
            wait_cycles = 0;
         end
      end
      pending_o = exp_exc_q.size();
   end

endmodule : mem_stage_checker

`default_nettype wire

/* rtl/mem_stage_top.sv */
`default_nettype none

module mem_stage_top import lsu_pkg::*, dbus_pkg::*; #(
   parameter int MEM_WORDS = 256
) (
   input  logic        clk,
   input  logic        rst_i,

   input  logic        exe_req_i,
   output logic        exe_ack_o,
   input  ld_ops_e     exe_ld_ops_i,
   input  st_ops_e     exe_st_ops_i,
   input  xlen_data_t  exe_alu_result_i,
   input  xlen_data_t  exe_rs2_data_i,
   input  xlen_data_t  exe_pc_next_i,
   input  reg_addr_t   exe_rd_addr_i,
   input  logic        exe_rd_wr_req_i,
   input  rd_wrb_sel_e exe_rd_wrb_sel_i,

   output logic        wrb_valid_o,
   output logic        wrb_rd_wr_o,
   output reg_addr_t   wrb_rd_addr_o,
   output xlen_data_t  wrb_data_o,
   output logic        exc_o,
   output xlen_data_t  exc_addr_o
);

   // lsu to bus controller
   logic        mem_valid;
   logic        mem_ready;
   dbus_addr_t  mem_addr;
   dbus_word_t  mem_wdata;
   dbus_be_t    mem_be;
   logic        mem_we;
   ld_ops_e     mem_ld_ops;
   reg_addr_t   mem_rd_addr;
   logic        mem_rd_wr_req;

   // lsu to writeback
   logic        byp_valid;
   logic        byp_ready;
   xlen_data_t  byp_alu_result;
   xlen_data_t  byp_pc_next;
   reg_addr_t   byp_rd_addr;
   logic        byp_rd_wr_req;
   rd_wrb_sel_e byp_rd_wrb_sel;
   logic        byp_misaligned;

   // Load extension loop
   dbus_word_t  ld_raw;
   ld_ops_e     ld_raw_ops;
   logic [1:0]  ld_raw_addr_lo;
   xlen_data_t  ld_ext_data;

   // Bus controller to writeback
   logic        ld_valid;
   xlen_data_t  ld_data;
   reg_addr_t   ld_rd_addr;
   logic        ld_rd_wr_req;

   // Data bus
   logic        dbus_req;
   logic        dbus_ack;
   dbus_addr_t  dbus_addr;
   logic        dbus_we;
   dbus_be_t    dbus_be;
   dbus_word_t  dbus_wdata;
   dbus_word_t  dbus_rdata;

   lsu u_lsu (
      .clk               (clk),
      .rst_i             (rst_i),
      .exe_req_i         (exe_req_i),
      .exe_ack_o         (exe_ack_o),
      .exe_ld_ops_i      (exe_ld_ops_i),
      .exe_st_ops_i      (exe_st_ops_i),
      .exe_alu_result_i  (exe_alu_result_i),
      .exe_rs2_data_i    (exe_rs2_data_i),
      .exe_pc_next_i     (exe_pc_next_i),
      .exe_rd_addr_i     (exe_rd_addr_i),
      .exe_rd_wr_req_i   (exe_rd_wr_req_i),
      .exe_rd_wrb_sel_i  (exe_rd_wrb_sel_i),
      .mem_valid_o       (mem_valid),
      .mem_ready_i       (mem_ready),
      .mem_addr_o        (mem_addr),
      .mem_wdata_o       (mem_wdata),
      .mem_be_o          (mem_be),
      .mem_we_o          (mem_we),
      .mem_ld_ops_o      (mem_ld_ops),
      .mem_rd_addr_o     (mem_rd_addr),
      .mem_rd_wr_req_o   (mem_rd_wr_req),
      .byp_valid_o       (byp_valid),
      .byp_ready_i       (byp_ready),
      .byp_alu_result_o  (byp_alu_result),
      .byp_pc_next_o     (byp_pc_next),
      .byp_rd_addr_o     (byp_rd_addr),
      .byp_rd_wr_req_o   (byp_rd_wr_req),
      .byp_rd_wrb_sel_o  (byp_rd_wrb_sel),
      .byp_misaligned_o  (byp_misaligned),
      .ld_raw_i          (ld_raw),
      .ld_raw_ops_i      (ld_raw_ops),
      .ld_raw_addr_lo_i  (ld_raw_addr_lo),
      .ld_data_o         (ld_ext_data)
   );

   lsu_dbus_ctrl u_lsu_dbus_ctrl (
      .clk               (clk),
      .rst_i             (rst_i),
      .mem_valid_i       (mem_valid),
      .mem_ready_o       (mem_ready),
      .mem_addr_i        (mem_addr),
      .mem_wdata_i       (mem_wdata),
      .mem_be_i          (mem_be),
      .mem_we_i          (mem_we),
      .mem_ld_ops_i      (mem_ld_ops),
      .mem_rd_addr_i     (mem_rd_addr),
      .mem_rd_wr_req_i   (mem_rd_wr_req),
      .dbus_req_o        (dbus_req),
      .dbus_ack_i        (dbus_ack),
      .dbus_addr_o       (dbus_addr),
      .dbus_we_o         (dbus_we),
      .dbus_be_o         (dbus_be),
      .dbus_wdata_o      (dbus_wdata),
      .dbus_rdata_i      (dbus_rdata),
      .ld_raw_o          (ld_raw),
      .ld_raw_ops_o      (ld_raw_ops),
      .ld_raw_addr_lo_o  (ld_raw_addr_lo),
      .ld_data_i         (ld_ext_data),
      .ld_valid_o        (ld_valid),
      .ld_data_o         (ld_data),
      .ld_rd_addr_o      (ld_rd_addr),
      .ld_rd_wr_req_o    (ld_rd_wr_req)
   );

   data_mem #(
      .MEM_WORDS (MEM_WORDS)
   ) u_data_mem (
      .clk          (clk),
      .rst_i        (rst_i),
      .dbus_req_i   (dbus_req),
      .dbus_ack_o   (dbus_ack),
      .dbus_addr_i  (dbus_addr),
      .dbus_we_i    (dbus_we),
      .dbus_be_i    (dbus_be),
      .dbus_wdata_i (dbus_wdata),
      .dbus_rdata_o (dbus_rdata)
   );

   lsu_wrb u_lsu_wrb (
      .clk              (clk),
      .rst_i            (rst_i),
      .byp_valid_i      (byp_valid),
      .byp_ready_o      (byp_ready),
      .byp_alu_result_i (byp_alu_result),
      .byp_pc_next_i    (byp_pc_next),
      .byp_rd_addr_i    (byp_rd_addr),
      .byp_rd_wr_req_i  (byp_rd_wr_req),
      .byp_rd_wrb_sel_i (byp_rd_wrb_sel),
      .byp_misaligned_i (byp_misaligned),
      .ld_valid_i       (ld_valid),
      .ld_data_i        (ld_data),
      .ld_rd_addr_i     (ld_rd_addr),
      .ld_rd_wr_req_i   (ld_rd_wr_req),
      .wrb_valid_o      (wrb_valid_o),
      .wrb_rd_wr_o      (wrb_rd_wr_o),
      .wrb_rd_addr_o    (wrb_rd_addr_o),
      .wrb_data_o       (wrb_data_o),
      .exc_o            (exc_o),
      .exc_addr_o       (exc_addr_o)
   );

endmodule : mem_stage_top

`default_nettype wire

/* rtl/lsu_wrb.sv */
`default_nettype none

module lsu_wrb import lsu_pkg::*; (
   input  logic        clk,
   input  logic        rst_i,

   // Bypass items from lsu
   input  logic        byp_valid_i,
   output logic        byp_ready_o,
   input  xlen_data_t  byp_alu_result_i,
   input  xlen_data_t  byp_pc_next_i,
   input  reg_addr_t   byp_rd_addr_i,
   input  logic        byp_rd_wr_req_i,
   input  rd_wrb_sel_e byp_rd_wrb_sel_i,
   input  logic        byp_misaligned_i,

   // Completed memory operations
   input  logic        ld_valid_i,
   input  xlen_data_t  ld_data_i,
   input  reg_addr_t   ld_rd_addr_i,
   input  logic        ld_rd_wr_req_i,

   output logic        wrb_valid_o,
   output logic        wrb_rd_wr_o,
   output reg_addr_t   wrb_rd_addr_o,
   output xlen_data_t  wrb_data_o,
   output logic        exc_o,
   output xlen_data_t  exc_addr_o
);

   logic       byp_xfer;
   logic       byp_ok;
   xlen_data_t byp_data;

   // Nothing downstream can stall this stage
   assign byp_ready_o = 1'b1;
   assign byp_xfer    = byp_valid_i && byp_ready_o;
   assign byp_ok      = byp_xfer && !byp_misaligned_i;

   always_comb begin
      case (byp_rd_wrb_sel_i)
         RD_WRB_PC_NEXT: byp_data = byp_pc_next_i;
         default:        byp_data = byp_alu_result_i;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         wrb_valid_o <= 1'b0;
         wrb_rd_wr_o <= 1'b0;
         exc_o       <= 1'b0;
      end else begin
         wrb_valid_o <= ld_valid_i || byp_ok;
         wrb_rd_wr_o <= ld_valid_i ? ld_rd_wr_req_i : (byp_ok && byp_rd_wr_req_i);
         exc_o       <= byp_xfer && byp_misaligned_i;
      end
   end

   // Load path items always carry memory data
   always_ff @(posedge clk) begin
      if (ld_valid_i) begin
         wrb_rd_addr_o <= ld_rd_addr_i;
         wrb_data_o    <= ld_data_i;
      end else if (byp_xfer) begin
         wrb_rd_addr_o <= byp_rd_addr_i;
         wrb_data_o    <= byp_data;
         exc_addr_o    <= byp_alu_result_i;
      end
   end

endmodule : lsu_wrb

`default_nettype wire

/* rtl/data_mem.sv */
`default_nettype none

module data_mem import dbus_pkg::*; #(
   parameter int MEM_WORDS = 256
) (
   input  logic       clk,
   input  logic       rst_i,
   input  logic       dbus_req_i,
   output logic       dbus_ack_o,
   input  dbus_addr_t dbus_addr_i,
   input  logic       dbus_we_i,
   input  dbus_be_t   dbus_be_i,
   input  dbus_word_t dbus_wdata_i,
   output dbus_word_t dbus_rdata_o
);

   localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

   dbus_word_t       mem [MEM_WORDS];
   logic [IDX_W-1:0] word_idx;
   logic             access;

   // Word index, upper address bits wrap around
   assign word_idx = dbus_addr_i[IDX_W+1:2];

   // Serve a request once, on the edge it is first seen
   assign access = dbus_req_i && !dbus_ack_o;

   // Ack follows req by one edge in both directions
   always_ff @(posedge clk) begin
      if (rst_i) begin
         dbus_ack_o <= 1'b0;
      end else begin
         dbus_ack_o <= dbus_req_i;
      end
   end

   always_ff @(posedge clk) begin
      if (access) begin
         if (dbus_we_i) begin
            for (int lane = 0; lane < 4; lane++) begin
               if (dbus_be_i[lane]) begin
                  mem[word_idx][8*lane +: 8] <= dbus_wdata_i[8*lane +: 8];
               end
            end
         end
         dbus_rdata_o <= mem[word_idx];
      end
   end

endmodule : data_mem

`default_nettype wire

/* lsu/lsu_dbus_ctrl.sv */
`default_nettype none

module lsu_dbus_ctrl import lsu_pkg::*, dbus_pkg::*; (
   input  logic       clk,
   input  logic       rst_i,

   // Memory operation from lsu
   input  logic       mem_valid_i,
   output logic       mem_ready_o,
   input  dbus_addr_t mem_addr_i,
   input  dbus_word_t mem_wdata_i,
   input  dbus_be_t   mem_be_i,
   input  logic       mem_we_i,
   input  ld_ops_e    mem_ld_ops_i,
   input  reg_addr_t  mem_rd_addr_i,
   input  logic       mem_rd_wr_req_i,

   // Data bus master
   output logic       dbus_req_o,
   input  logic       dbus_ack_i,
   output dbus_addr_t dbus_addr_o,
   output logic       dbus_we_o,
   output dbus_be_t   dbus_be_o,
   output dbus_word_t dbus_wdata_o,
   input  dbus_word_t dbus_rdata_i,

   // Extension path in lsu
   output dbus_word_t ld_raw_o,
   output ld_ops_e    ld_raw_ops_o,
   output logic [1:0] ld_raw_addr_lo_o,
   input  xlen_data_t ld_data_i,

   // Result to writeback
   output logic       ld_valid_o,
   output xlen_data_t ld_data_o,
   output reg_addr_t  ld_rd_addr_o,
   output logic       ld_rd_wr_req_o
);

   dbus_state_e state;
   logic        accept;
   logic        ack_seen;
   logic        ld_valid_q;
   xlen_data_t  ld_data_q;

   dbus_addr_t  op_addr_q;
   dbus_word_t  op_wdata_q;
   dbus_be_t    op_be_q;
   logic        op_we_q;
   ld_ops_e     op_ld_ops_q;
   reg_addr_t   op_rd_addr_q;
   logic        op_rd_wr_req_q;

   assign mem_ready_o = (state == DBUS_IDLE);
   assign accept      = mem_valid_i && mem_ready_o;
   assign ack_seen    = (state == DBUS_REQ) && dbus_ack_i;

   always_ff @(posedge clk) begin
      if (rst_i) begin
         state      <= DBUS_IDLE;
         ld_valid_q <= 1'b0;
      end else begin
         ld_valid_q <= ack_seen;
         case (state)
            DBUS_IDLE: begin
               if (accept) begin
                  state <= DBUS_REQ;
               end
            end
            DBUS_REQ: begin
               if (dbus_ack_i) begin
                  state <= DBUS_RELEASE;
               end
            end
            // Hold off until the slave has dropped ack
            DBUS_RELEASE: begin
               if (!dbus_ack_i) begin
                  state <= DBUS_IDLE;
               end
            end
            default: state <= DBUS_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         op_addr_q      <= mem_addr_i;
         op_wdata_q     <= mem_wdata_i;
         op_be_q        <= mem_be_i;
         op_we_q        <= mem_we_i;
         op_ld_ops_q    <= mem_ld_ops_i;
         op_rd_addr_q   <= mem_rd_addr_i;
         op_rd_wr_req_q <= mem_rd_wr_req_i;
      end
      if (ack_seen) begin
         ld_data_q <= ld_data_i;
      end
   end

   assign dbus_req_o   = (state == DBUS_REQ);
   assign dbus_addr_o  = op_addr_q;
   assign dbus_we_o    = op_we_q;
   assign dbus_be_o    = op_be_q;
   assign dbus_wdata_o = op_wdata_q;

   assign ld_raw_o         = dbus_rdata_i;
   assign ld_raw_ops_o     = op_ld_ops_q;
   assign ld_raw_addr_lo_o = op_addr_q[1:0];

   // A store completes with its register write disabled
   assign ld_valid_o     = ld_valid_q;
   assign ld_data_o      = ld_data_q;
   assign ld_rd_addr_o   = op_rd_addr_q;
   assign ld_rd_wr_req_o = op_rd_wr_req_q && (op_ld_ops_q != LD_OPS_NONE);

endmodule : lsu_dbus_ctrl

`default_nettype wire

/* lsu/lsu.sv */
`default_nettype none

module lsu import lsu_pkg::*, dbus_pkg::*; (
   input  logic        clk,
   input  logic        rst_i,

   // Execute port, four-phase
   input  logic        exe_req_i,
   output logic        exe_ack_o,
   input  ld_ops_e     exe_ld_ops_i,
   input  st_ops_e     exe_st_ops_i,
   input  xlen_data_t  exe_alu_result_i,
   input  xlen_data_t  exe_rs2_data_i,
   input  xlen_data_t  exe_pc_next_i,
   input  reg_addr_t   exe_rd_addr_i,
   input  logic        exe_rd_wr_req_i,
   input  rd_wrb_sel_e exe_rd_wrb_sel_i,

   // Memory path to the bus controller
   output logic        mem_valid_o,
   input  logic        mem_ready_i,
   output dbus_addr_t  mem_addr_o,
   output dbus_word_t  mem_wdata_o,
   output dbus_be_t    mem_be_o,
   output logic        mem_we_o,
   output ld_ops_e     mem_ld_ops_o,
   output reg_addr_t   mem_rd_addr_o,
   output logic        mem_rd_wr_req_o,

   // Bypass path to writeback
   output logic        byp_valid_o,
   input  logic        byp_ready_i,
   output xlen_data_t  byp_alu_result_o,
   output xlen_data_t  byp_pc_next_o,
   output reg_addr_t   byp_rd_addr_o,
   output logic        byp_rd_wr_req_o,
   output rd_wrb_sel_e byp_rd_wrb_sel_o,
   output logic        byp_misaligned_o,

   // Load extension, driven by the bus controller
   input  dbus_word_t  ld_raw_i,
   input  ld_ops_e     ld_raw_ops_i,
   input  logic [1:0]  ld_raw_addr_lo_i,
   output xlen_data_t  ld_data_o
);

   logic        ack_q;
   logic        full_q;
   ld_ops_e     ld_ops_q;
   st_ops_e     st_ops_q;
   xlen_data_t  addr_q;
   xlen_data_t  rs2_q;
   xlen_data_t  pc_next_q;
   reg_addr_t   rd_addr_q;
   logic        rd_wr_req_q;
   rd_wrb_sel_e wrb_sel_q;

   logic        capture;
   logic        release_item;
   logic        is_mem;
   logic        is_half;
   logic        is_word;
   logic        misaligned;
   logic        mem_path;
   logic [7:0]  ld_byte;
   logic [15:0] ld_half;

   // Take a request only when empty and the previous one has been released
   assign capture = exe_req_i && !ack_q && !full_q;
   assign release_item = (mem_valid_o && mem_ready_i) || (byp_valid_o && byp_ready_i);

   always_ff @(posedge clk) begin
      if (rst_i) begin
         ack_q  <= 1'b0;
         full_q <= 1'b0;
      end else begin
         if (capture) begin
            ack_q <= 1'b1;
         end else if (!exe_req_i) begin
            ack_q <= 1'b0;
         end
         if (capture) begin
            full_q <= 1'b1;
         end else if (release_item) begin
            full_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (capture) begin
         ld_ops_q    <= exe_ld_ops_i;
         st_ops_q    <= exe_st_ops_i;
         addr_q      <= exe_alu_result_i;
         rs2_q       <= exe_rs2_data_i;
         pc_next_q   <= exe_pc_next_i;
         rd_addr_q   <= exe_rd_addr_i;
         rd_wr_req_q <= exe_rd_wr_req_i;
         wrb_sel_q   <= exe_rd_wrb_sel_i;
      end
   end

   assign exe_ack_o = ack_q;

   // Access size and alignment
   assign is_mem  = (ld_ops_q != LD_OPS_NONE) || (st_ops_q != ST_OPS_NONE);
   assign is_half = (ld_ops_q == LD_OPS_LH) || (ld_ops_q == LD_OPS_LHU) ||
                    (st_ops_q == ST_OPS_SH);
   assign is_word = (ld_ops_q == LD_OPS_LW) || (st_ops_q == ST_OPS_SW);
   assign misaligned = (is_half && addr_q[0]) || (is_word && (addr_q[1:0] != 2'b00));
   assign mem_path = is_mem && !misaligned;

   // Bypass waits for an idle bus controller so results stay in order
   assign mem_valid_o = full_q && mem_path;
   assign byp_valid_o = full_q && !mem_path && mem_ready_i;

   assign mem_addr_o      = addr_q;
   assign mem_we_o        = (st_ops_q != ST_OPS_NONE);
   assign mem_ld_ops_o    = ld_ops_q;
   assign mem_rd_addr_o   = rd_addr_q;
   assign mem_rd_wr_req_o = rd_wr_req_q;

   // Replicate store data across lanes, enables pick the lanes written
   always_comb begin
      mem_wdata_o = rs2_q;
      mem_be_o    = 4'b1111;
      if (is_half) begin
         mem_wdata_o = {2{rs2_q[15:0]}};
         mem_be_o    = addr_q[1] ? 4'b1100 : 4'b0011;
      end else if (!is_word) begin
         mem_wdata_o = {4{rs2_q[7:0]}};
         mem_be_o    = 4'b0001 << addr_q[1:0];
      end
   end

   assign byp_alu_result_o = addr_q;
   assign byp_pc_next_o    = pc_next_q;
   assign byp_rd_addr_o    = rd_addr_q;
   assign byp_rd_wr_req_o  = rd_wr_req_q;
   assign byp_rd_wrb_sel_o = wrb_sel_q;
   assign byp_misaligned_o = misaligned;

   // Pick the addressed byte or halfword and extend it
   always_comb begin
      ld_byte = ld_raw_i[8*ld_raw_addr_lo_i +: 8];
      ld_half = ld_raw_addr_lo_i[1] ? ld_raw_i[31:16] : ld_raw_i[15:0];
      case (ld_raw_ops_i)
         LD_OPS_LB:  ld_data_o = {{24{ld_byte[7]}}, ld_byte};
         LD_OPS_LBU: ld_data_o = {24'b0, ld_byte};
         LD_OPS_LH:  ld_data_o = {{16{ld_half[15]}}, ld_half};
         LD_OPS_LHU: ld_data_o = {16'b0, ld_half};
         LD_OPS_LW:  ld_data_o = ld_raw_i;
         default:    ld_data_o = '0;
      endcase
   end

endmodule : lsu

`default_nettype wire

/* common/dbus_pkg.sv */
`default_nettype none

package dbus_pkg;

   typedef logic [31:0] dbus_addr_t;
   typedef logic [31:0] dbus_word_t;

   // One enable bit per byte lane
   typedef logic [3:0]  dbus_be_t;

   // Bus master sequence, request then wait for ack to drop
   typedef enum logic [1:0] {
      DBUS_IDLE    = 2'd0,
      DBUS_REQ     = 2'd1,
      DBUS_RELEASE = 2'd2
   } dbus_state_e;

endpackage : dbus_pkg

`default_nettype wire

/* common/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

   // Register file values and indices
   typedef logic [31:0] xlen_data_t;
   typedef logic [4:0]  reg_addr_t;

   // Load operation, anything but NONE is a load
   typedef enum logic [2:0] {
      LD_OPS_NONE = 3'd0,
      LD_OPS_LB   = 3'd1,
      LD_OPS_LBU  = 3'd2,
      LD_OPS_LH   = 3'd3,
      LD_OPS_LHU  = 3'd4,
      LD_OPS_LW   = 3'd5
   } ld_ops_e;

   typedef enum logic [1:0] {
      ST_OPS_NONE = 2'd0,
      ST_OPS_SB   = 2'd1,
      ST_OPS_SH   = 2'd2,
      ST_OPS_SW   = 2'd3
   } st_ops_e;

   // Source of the value written back to rd
   typedef enum logic [1:0] {
      RD_WRB_ALU     = 2'd0,
      RD_WRB_MEM     = 2'd1,
      RD_WRB_PC_NEXT = 2'd2
   } rd_wrb_sel_e;

endpackage : lsu_pkg

`default_nettype wire
